/* hw/num_pkg.sv */
// signed two's complement only; SUM_WIDTH is tied to a three-level tree and vec_pkg checks it
`default_nettype none

package num_pkg;

    // numeric formats of the dot-product datapath
    // every value is signed two's complement
    // no saturation or rounding anywhere, widths grow instead

    // one element of an embedding vector
    localparam int INTEGER_WIDTH = 8;

    // exact product of two elements
    // -128 * -128 = 16384 still fits
    localparam int PRODUCT_WIDTH = 2 * INTEGER_WIDTH;

    // each pairwise level adds one bit of growth
    // three levels for eight elements
    localparam int SUM_WIDTH = PRODUCT_WIDTH + 3;

    // single operand element
    typedef logic signed [INTEGER_WIDTH-1:0] operand_t;

    // single element product
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

    // final dot product
    // range is 8 * 16384 at most
    typedef logic signed [SUM_WIDTH-1:0] sum_t;

endpackage

`default_nettype wire

/* hw/vec_pkg.sv */
// fixed vector length only; the length must stay a power of two for the pairwise reduction tree
`default_nettype none

package vec_pkg;

    import num_pkg::*;

    // elements per vector
    localparam int MAX_EMBEDDING_DIM = 8;

    // pairwise levels to reach a single sum
    localparam int TREE_DEPTH = $clog2(MAX_EMBEDDING_DIM);

    // sum width must cover the tree growth
    // a mismatch gives a negative replication count and stops elaboration
    localparam int SUM_WIDTH_OK = (SUM_WIDTH == PRODUCT_WIDTH + TREE_DEPTH) ? 1 : -1;
    localparam logic [0:0] SUM_WIDTH_CHECK = {SUM_WIDTH_OK{1'b1}};

    // element 0 sits in the low bits
    typedef operand_t [MAX_EMBEDDING_DIM-1:0] operand_vec_t;

    // products keep the element order of the operands
    typedef product_t [MAX_EMBEDDING_DIM-1:0] product_vec_t;

    // both input vectors move as one item
    // a is the upper half of the packed bits
    typedef struct packed {
        operand_vec_t a;
        operand_vec_t b;
    } operand_pair_t;

endpackage

`default_nettype wire

/* hw/elementwise_mult.sv */
// holds one operand pair at a time; products are exact and appear the cycle after acceptance
`default_nettype none

module elementwise_mult (
    input  logic                   clock,
    input  logic                   reset,

    // upstream side
    input  logic                   in_valid,
    output logic                   in_ready,
    input  vec_pkg::operand_pair_t operands,

    // downstream side
    input  logic                   out_ready,
    output logic                   out_valid,
    output vec_pkg::product_vec_t  products
);

    import num_pkg::*;
    import vec_pkg::*;

    // single item holding register
    operand_pair_t pair_q;
    logic          valid_q;

    // ready when empty or when the held pair leaves this edge
    // combinational path from out_ready back to in_ready
    assign in_ready = out_ready || !valid_q;

    // item is presented as long as it is held
    assign out_valid = valid_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            pair_q  <= '0;
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            // load a new pair, may replace one leaving now
            pair_q  <= operands;
            valid_q <= 1'b1;
        end else if (out_ready) begin
            // held pair taken, nothing new arrives
            valid_q <= 1'b0;
        end
    end

    // products from the register, not from the input
    // pair_q only changes on acceptance so products stay stable under stall
    always_comb begin
        for (int i = 0; i < MAX_EMBEDDING_DIM; i++) begin
            // widen both factors first
            // the product then fits exactly in PRODUCT_WIDTH
            products[i] = product_t'($signed(pair_q.a[i])) *
                          product_t'($signed(pair_q.b[i]));
        end
    end

endmodule

`default_nettype wire

/* hw/reduction_step.sv */
// INPUT_LEN must be a power of two and at least 2**STEPS; one list in flight, no overflow
`default_nettype none

module reduction_step #(
    parameter  int INPUT_LEN  = vec_pkg::MAX_EMBEDDING_DIM,
    parameter  int W_IN       = num_pkg::PRODUCT_WIDTH,
    parameter  int STEPS      = 1,
    // one bit of growth per level
    localparam int W_OUT      = W_IN + STEPS,
    // list halves on each level
    localparam int OUTPUT_LEN = INPUT_LEN >> STEPS
) (
    input  logic                                  clock,
    input  logic                                  reset,

    // upstream side
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic signed [INPUT_LEN-1:0][W_IN-1:0] list_in,

    // downstream side
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic signed [OUTPUT_LEN-1:0][W_OUT-1:0] list_out
);

    // all tree nodes in one flat array
    // leaves first, then each level, the outputs are the last entries
    localparam int NODES = 2 * INPUT_LEN - OUTPUT_LEN;

    logic [INPUT_LEN-1:0][W_IN-1:0] list_q;
    logic                           valid_q;

    logic signed [W_OUT-1:0] node [NODES];

    // stop elaboration on a length the tree cannot halve cleanly
    if (STEPS < 1 || INPUT_LEN < (1 << STEPS) || (INPUT_LEN & (INPUT_LEN - 1)) != 0) begin
        : g_bad_len
        $error("reduction_step needs a power of two INPUT_LEN of at least 2**STEPS");
    end

    // same handshake as the multiply stage
    assign in_ready  = out_ready || !valid_q;
    assign out_valid = valid_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    // list only moves on acceptance
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            list_q <= list_in;
        end
    end

    // leaves, sign extended to the output width
    for (genvar i = 0; i < INPUT_LEN; i++) begin : g_leaf
        assign node[i] = {{STEPS{list_q[i][W_IN-1]}}, list_q[i]};
    end

    // level s starts at 2*(INPUT_LEN - INPUT_LEN>>s)
    for (genvar s = 0; s < STEPS; s++) begin : g_level
        localparam int SRC = 2 * (INPUT_LEN - (INPUT_LEN >> s));
        localparam int DST = 2 * (INPUT_LEN - (INPUT_LEN >> (s + 1)));
        // adjacent pairs of the level below
        for (genvar i = 0; i < (INPUT_LEN >> (s + 1)); i++) begin : g_pair
            assign node[DST+i] = node[SRC+2*i] + node[SRC+2*i+1];
        end
    end

    // last level is the result list
    for (genvar i = 0; i < OUTPUT_LEN; i++) begin : g_out
        assign list_out[i] = node[NODES-OUTPUT_LEN+i];
    end

endmodule

`default_nettype wire

/* hw/dot_product.sv */
// three stage pipeline, result 3 cycles after acceptance; no accumulation across vectors
`default_nettype none

module dot_product (
    input  logic                   clock,
    input  logic                   reset,

    // operand vectors in
    input  logic                   in_valid,
    output logic                   in_ready,
    input  vec_pkg::operand_pair_t operands,

    // dot product out
    output logic                   out_valid,
    input  logic                   out_ready,
    output num_pkg::sum_t          dot
);

    import num_pkg::*;
    import vec_pkg::*;

    // multiply to first reduction
    logic         prod_valid;
    logic         prod_ready;
    product_vec_t products;

    // first reduction to second
    // two partial sums of four products each
    logic         partial_valid;
    logic         partial_ready;
    logic [(MAX_EMBEDDING_DIM >> (TREE_DEPTH - 1))-1:0][PRODUCT_WIDTH+TREE_DEPTH-2:0] partial;

    // single element result list
    logic [0:0][SUM_WIDTH-1:0] dot_list;

    // element products
    elementwise_mult u_mult (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .operands  (operands),
        .out_ready (prod_ready),
        .out_valid (prod_valid),
        .products  (products)
    );

    // eight products down to two
    reduction_step #(
        .INPUT_LEN (MAX_EMBEDDING_DIM),
        .W_IN      (PRODUCT_WIDTH),
        .STEPS     (TREE_DEPTH - 1)
    ) u_reduce_hi (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (prod_valid),
        .in_ready  (prod_ready),
        .list_in   (products),
        .out_valid (partial_valid),
        .out_ready (partial_ready),
        .list_out  (partial)
    );

    // last pair to the final sum
    reduction_step #(
        .INPUT_LEN (MAX_EMBEDDING_DIM >> (TREE_DEPTH - 1)),
        .W_IN      (PRODUCT_WIDTH + TREE_DEPTH - 1),
        .STEPS     (1)
    ) u_reduce_lo (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (partial_valid),
        .in_ready  (partial_ready),
        .list_in   (partial),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .list_out  (dot_list)
    );

    assign dot = dot_list[0];

endmodule

`default_nettype wire

/* tests/dot_product_properties.sv */
// watches only the top-level ports of dot_product; reset is synchronous and active high
`default_nettype none

module dot_product_properties (
    input logic          clock,
    input logic          reset,
    input logic          in_ready,
    input logic          out_valid,
    input logic          out_ready,
    input num_pkg::sum_t dot
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled result stays put until taken
    hold_while_stalled: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(dot)
    ) else $error("dot_product result changed or vanished while stalled");

    // reset empties every stage
    empty_after_reset: assert property (
        @(posedge clock)
        reset |=> !out_valid
    ) else $error("dot_product presented a result right after reset");

    // ready runs back through all three stages
    // so a ready sink never blocks the input
    ready_passes_back: assert property (
        @(posedge clock) disable iff (reset)
        out_ready |-> in_ready
    ) else $error("dot_product input stalled while the output was ready");

endmodule

bind dot_product dot_product_properties dot_product_properties_inst (
    .clock     (clock),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .dot       (dot)
);

`default_nettype wire

/* tests/dot_product_tb.sv */
// self-checking testbench for dot_product; needs timing support, fixed seed, all waits bounded
`default_nettype none

module dot_product_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import num_pkg::*;
    import vec_pkg::*;

    // bounds for the wait loops
    localparam int ACCEPT_TIMEOUT    = 200;
    localparam int RESULT_TIMEOUT    = 20;
    localparam int DRAIN_TIMEOUT     = 500;
    localparam int RANDOM_ITEMS      = 300;
    localparam int READY_PATTERN_LEN = 1024;

    logic          clock;
    logic          reset;
    logic          in_valid;
    logic          in_ready;
    operand_pair_t operands;
    logic          out_valid;
    logic          out_ready = 1'b1;
    sum_t          dot;

    // stimulus control
    int            seed;
    logic          backpressure;
    logic          ready_pattern [READY_PATTERN_LEN];
    int            ready_index = 0;

    // expected results in acceptance order
    sum_t          expected_q[$];

    // owned by the compare process
    int            mismatch_count = 0;
    int            unexpected_count = 0;
    int            result_count = 0;
    // owned by the main sequence
    int            protocol_count = 0;
    int            timeout_count = 0;
    int            accept_count = 0;

    dot_product dot_product_inst (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .operands  (operands),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .dot       (dot)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // last resort against a stuck run
    initial begin
        #5_000_000;
        $display("Error: simulation ran past its time limit");
        $display("SIMULATION FAILED");
        $finish;
    end

    // signed dot product in plain integer arithmetic
    function automatic sum_t reference_dot(input operand_pair_t pair);
        int       acc;
        operand_t ea;
        operand_t eb;
        acc = 0;
        for (int i = 0; i < MAX_EMBEDDING_DIM; i++) begin
            ea  = pair.a[i];
            eb  = pair.b[i];
            acc = acc + int'(ea) * int'(eb);
        end
        return sum_t'(acc);
    endfunction

    function automatic operand_pair_t random_pair();
        operand_pair_t pair;
        logic [31:0]   rnd;
        for (int i = 0; i < MAX_EMBEDDING_DIM; i++) begin
            rnd       = $random(seed);
            pair.a[i] = rnd[INTEGER_WIDTH-1:0];
            pair.b[i] = rnd[2*INTEGER_WIDTH-1:INTEGER_WIDTH];
        end
        return pair;
    endfunction

    // even and odd elements get their own value
    function automatic operand_pair_t fill_pair(input operand_t a_even, input operand_t a_odd,
                                                input operand_t b_even, input operand_t b_odd);
        operand_pair_t pair;
        for (int i = 0; i < MAX_EMBEDDING_DIM; i++) begin
            pair.a[i] = (i % 2 == 0) ? a_even : a_odd;
            pair.b[i] = (i % 2 == 0) ? b_even : b_odd;
        end
        return pair;
    endfunction

    // out_ready moves 10 ns after each edge
    always @(posedge clock) begin
        #10;
        if (backpressure) begin
            out_ready   = ready_pattern[ready_index];
            ready_index = (ready_index + 1) % READY_PATTERN_LEN;
        end else begin
            out_ready = 1'b1;
        end
    end

    // scoreboard, one compare per output transfer
    always @(posedge clock) begin
        sum_t expected;
        if (!reset && out_valid && out_ready) begin
            result_count++;
            assert (expected_q.size() != 0) else begin
                $display("Error: a result left the DUT with no input outstanding");
                unexpected_count++;
            end
            if (expected_q.size() != 0) begin
                expected = expected_q.pop_front();
                assert (dot == expected) else begin
                    $display("Mismatch dot: expected 0x%h, actual 0x%h", expected, dot);
                    mismatch_count++;
                end
            end
        end
    end

    // called 10 ns after an edge, returns 10 ns after the accepting edge
    // in_valid stays high on return
    task automatic send_item(input operand_pair_t pair, output int waited);
        int cycles;
        bit taken;
        cycles   = 0;
        taken    = 1'b0;
        in_valid = 1'b1;
        operands = pair;
        while (!taken && cycles < ACCEPT_TIMEOUT) begin
            @(posedge clock);
            cycles++;
            if (in_ready) begin
                taken = 1'b1;
            end
        end
        if (taken) begin
            expected_q.push_back(reference_dot(pair));
            accept_count++;
        end else begin
            $display("Error: input was not accepted within %0d cycles", ACCEPT_TIMEOUT);
            timeout_count++;
        end
        #10;
        waited = cycles;
    endtask

    task automatic idle_cycle();
        in_valid = 1'b0;
        @(posedge clock);
        #10;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("Error: %0d results still missing after %0d cycles",
                     expected_q.size(), DRAIN_TIMEOUT);
            timeout_count++;
        end
        @(posedge clock);
        #10;
    endtask

    // nothing held, nothing presented
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            assert (!out_valid) else begin
                $display("Mismatch out_valid: expected 0x0, actual 0x%h", out_valid);
                protocol_count++;
            end
            assert (in_ready) else begin
                $display("Mismatch in_ready: expected 0x1, actual 0x%h", in_ready);
                protocol_count++;
            end
        end
        #10;
    endtask

    // count edges from acceptance to the first out_valid
    task automatic check_latency();
        int waited;
        int cycles;
        bit seen;
        send_item(random_pair(), waited);
        in_valid = 1'b0;
        cycles   = 0;
        seen     = 1'b0;
        while (!seen && cycles < RESULT_TIMEOUT) begin
            @(posedge clock);
            cycles++;
            if (out_valid) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("Error: no result within %0d cycles of a single input", RESULT_TIMEOUT);
            timeout_count++;
        end else begin
            assert (cycles == 3) else begin
                $display("Error: result came %0d cycles after acceptance instead of 3", cycles);
                protocol_count++;
            end
        end
        #10;
    endtask

    // with out_ready high every input goes in at the first edge
    task automatic run_back_to_back(input int count);
        int waited;
        for (int n = 0; n < count; n++) begin
            send_item(random_pair(), waited);
            assert (waited == 1) else begin
                $display("Error: back-to-back input %0d waited %0d cycles", n, waited);
                protocol_count++;
            end
        end
        in_valid = 1'b0;
    endtask

    // random gaps on the input side
    task automatic run_random(input int count);
        logic [31:0] rnd;
        int          waited;
        int          sent;
        sent = 0;
        while (sent < count && timeout_count == 0) begin
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) begin
                idle_cycle();
            end else begin
                send_item(random_pair(), waited);
                sent++;
            end
        end
        in_valid = 1'b0;
    endtask

    // corner values at the full sum width
    task automatic run_extremes();
        int waited;
        send_item(fill_pair(operand_t'(-128), operand_t'(-128),
                            operand_t'(-128), operand_t'(-128)), waited);
        send_item(fill_pair(operand_t'(127), operand_t'(127),
                            operand_t'(-128), operand_t'(-128)), waited);
        send_item(fill_pair(operand_t'(127), operand_t'(127),
                            operand_t'(127), operand_t'(127)), waited);
        // products alternate in sign
        send_item(fill_pair(operand_t'(-128), operand_t'(127),
                            operand_t'(-128), operand_t'(-128)), waited);
        send_item(fill_pair(operand_t'(127), operand_t'(-128),
                            operand_t'(-128), operand_t'(127)), waited);
        in_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        seed         = 32'h1e6674bd;
        reset        = 1'b1;
        in_valid     = 1'b0;
        operands     = '0;
        backpressure = 1'b0;
        // about half the cycles stalled
        for (int i = 0; i < READY_PATTERN_LEN; i++) begin
            rnd              = $random(seed);
            ready_pattern[i] = rnd[0];
        end
        repeat (8) @(posedge clock);
        #10;
        reset = 1'b0;

        check_idle(4);
        check_latency();
        wait_drain();
        if (timeout_count == 0) begin
            run_back_to_back(16);
            wait_drain();
        end
        if (timeout_count == 0) begin
            backpressure = 1'b1;
            run_random(RANDOM_ITEMS);
            wait_drain();
            backpressure = 1'b0;
        end
        if (timeout_count == 0) begin
            run_extremes();
            wait_drain();
        end

        assert (expected_q.size() == 0) else begin
            $display("Error: %0d expected results never arrived", expected_q.size());
            protocol_count++;
        end
        assert (result_count == accept_count) else begin
            $display("Error: %0d inputs accepted but %0d results seen",
                     accept_count, result_count);
            protocol_count++;
        end
        $display("errors: mismatch %0d, unexpected %0d, protocol %0d, timeout %0d (in %0d, out %0d)",
                 mismatch_count, unexpected_count, protocol_count, timeout_count,
                 accept_count, result_count);
        if (mismatch_count + unexpected_count + protocol_count + timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/num_pkg.sv
hw/vec_pkg.sv
hw/elementwise_mult.sv
hw/reduction_step.sv
hw/dot_product.sv
tests/dot_product_properties.sv
tests/dot_product_tb.sv

/* Makefile */
# Verilator flow for the dot-product engine

VERILATOR ?= verilator
TOP       ?= dot_product_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
EXTRA     ?=

FAIL_MSG  := SIMULATION FAILED
PASS_MSG  := SIMULATION PASSED
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(EXTRA) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) $(EXTRA) --top-module $(TOP) \
	    -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "test failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	    echo "run ended without a result, see $(LOG)"; exit 1; \
	else \
	    echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
